//--- include/mc_bridge_cfg.svh
//**************************************************************************
// bridge widths, queue sizes and DRAM window constants
// included by every bridge source file
//**************************************************************************
`ifndef MC_BRIDGE_CFG_SVH
`define MC_BRIDGE_CFG_SVH

// host word and packet sizes
`define MC_WORD_WIDTH 32
`define MC_REQ_WORDS  4
`define MC_RSP_WORDS  2
`define MC_REQ_WIDTH  112
`define MC_RSP_WIDTH  48

// word queues per direction
`define MC_NUM_CHAN   6
`define MC_FIFO_DEPTH 4

// DRAM window
`define MC_ADDR_WIDTH 32
`define MC_ADDR_FLIP  32'h8000_0000
// 120 MiB
`define MC_MEM_LIMIT  32'd125829120

// one profiler bit per 8 MiB region
`define MC_PROF_BITS  128
`define MC_PROF_LSB   23

`endif

//--- source/mc_bridge_pkg.sv
//**************************************************************************
// shared types of the host bridge: host word, register and queue indices
//**************************************************************************
`include "mc_bridge_cfg.svh"

package mc_bridge_pkg;

	typedef logic [`MC_WORD_WIDTH-1:0] mc_word_t;

	// host register index, holes read as zero
	typedef enum logic [3:0]
	{
		CSR_CTRL   = 4'd0,
		CSR_BASE   = 4'd2,
		CSR_STATUS = 4'd3,
		CSR_PROF0  = 4'd4,
		CSR_PROF1  = 4'd5,
		CSR_PROF2  = 4'd6,
		CSR_PROF3  = 4'd7
	} csr_addr_e;

	// word queue index, same numbering in both directions
	typedef enum logic [2:0]
	{
		CH_REQ0 = 3'd0,
		CH_REQ1 = 3'd1,
		CH_REQ2 = 3'd2,
		CH_REQ3 = 3'd3,
		CH_RSP0 = 3'd4,
		CH_RSP1 = 3'd5
	} chan_e;

endpackage

//--- source/word_fifo.sv
//**************************************************************************
// small synchronous word queue, valid/ready in and valid/yumi out
// writers raise w_v_i only while w_ready_o is high
//**************************************************************************
`include "mc_bridge_cfg.svh"

module word_fifo
	import mc_bridge_pkg::*;
#(
	parameter int depth_p = `MC_FIFO_DEPTH
)
(
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  logic     w_v_i,
	input  mc_word_t w_data_i,
	output logic     w_ready_o,
	output logic     r_v_o,
	output mc_word_t r_data_o,
	input  logic     r_yumi_i
);
	localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
	localparam int cnt_w_lp = $clog2(depth_p + 1);

	mc_word_t mem [depth_p];
	logic [ptr_w_lp-1:0] wr_ptr_r;
	logic [ptr_w_lp-1:0] rd_ptr_r;
	logic [cnt_w_lp-1:0] count_r;

	// circular pointer step
	function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
		if (ptr == ptr_w_lp'(depth_p - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign w_ready_o = (count_r != cnt_w_lp'(depth_p));
	assign r_v_o     = (count_r != '0);
	assign r_data_o  = mem[rd_ptr_r];

	always_ff @(posedge clk_i)
	begin
		if (w_v_i)
		begin
			mem[wr_ptr_r] <= w_data_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r  <= '0;
		end
		else
		begin
			if (w_v_i)
				wr_ptr_r <= next_ptr(wr_ptr_r);
			if (r_yumi_i)
				rd_ptr_r <= next_ptr(rd_ptr_r);
			count_r <= count_r + cnt_w_lp'(w_v_i) - cnt_w_lp'(r_yumi_i);
		end
	end

	// upstream logic must respect full, downstream must respect empty
	a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		w_v_i |-> w_ready_o);
	a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		r_yumi_i |-> r_v_o);

endmodule

//--- source/packet_gather.sv
//**************************************************************************
// host-to-fabric side: six word queues gathered into request and
// response packets, a whole group leaves on one handshake
//**************************************************************************
`include "mc_bridge_cfg.svh"

module packet_gather
	import mc_bridge_pkg::*;
(
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     push_v_i,
	input  chan_e                    push_chan_i,
	input  mc_word_t                 push_data_i,
	output logic                     push_ready_o,
	output logic [`MC_REQ_WIDTH-1:0] req_o,
	output logic                     req_v_o,
	input  logic                     req_ready_i,
	output logic [`MC_RSP_WIDTH-1:0] rsp_o,
	output logic                     rsp_v_o,
	input  logic                     rsp_ready_i
);
	localparam int req_top_w_lp = `MC_REQ_WIDTH - (`MC_REQ_WORDS - 1) * `MC_WORD_WIDTH;
	localparam int rsp_top_w_lp = `MC_RSP_WIDTH - (`MC_RSP_WORDS - 1) * `MC_WORD_WIDTH;

	logic [`MC_NUM_CHAN-1:0] w_v;
	logic [`MC_NUM_CHAN-1:0] w_ready;
	logic [`MC_NUM_CHAN-1:0] r_v;
	logic [`MC_NUM_CHAN-1:0] yumi;
	mc_word_t head [`MC_NUM_CHAN];
	logic req_go;
	logic rsp_go;

	// channels 6 and 7 never accept
	assign push_ready_o = (push_chan_i < `MC_NUM_CHAN) && w_ready[push_chan_i];

	for (genvar i = 0; i < `MC_NUM_CHAN; i++)
	begin : g_chan
		assign w_v[i] = push_v_i && push_ready_o && (int'(push_chan_i) == i);

		word_fifo #(.depth_p(`MC_FIFO_DEPTH)) fifo_inst
		(
			.clk_i     (clk_i),
			.rst_n_i   (rst_n_i),
			.w_v_i     (w_v[i]),
			.w_data_i  (push_data_i),
			.w_ready_o (w_ready[i]),
			.r_v_o     (r_v[i]),
			.r_data_o  (head[i]),
			.r_yumi_i  (yumi[i])
		);
	end

	// a packet is offered only when every word of it is present
	assign req_v_o = &r_v[`MC_REQ_WORDS-1:0];
	assign rsp_v_o = &r_v[`MC_REQ_WORDS +: `MC_RSP_WORDS];
	assign req_go  = req_v_o && req_ready_i;
	assign rsp_go  = rsp_v_o && rsp_ready_i;
	assign yumi    = {{`MC_RSP_WORDS{rsp_go}}, {`MC_REQ_WORDS{req_go}}};

	// word 0 in the low bits, upper bits of the top word dropped
	assign req_o = {head[CH_REQ3][req_top_w_lp-1:0], head[CH_REQ2], head[CH_REQ1],
		head[CH_REQ0]};
	assign rsp_o = {head[CH_RSP1][rsp_top_w_lp-1:0], head[CH_RSP0]};

	a_push_chan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_v_i |-> (push_chan_i < `MC_NUM_CHAN));

endmodule

//--- source/packet_scatter.sv
//**************************************************************************
// fabric-to-host side: inbound packets split into six word queues,
// host pops one word at a time from the selected channel
//**************************************************************************
`include "mc_bridge_cfg.svh"

module packet_scatter
	import mc_bridge_pkg::*;
(
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic [`MC_REQ_WIDTH-1:0] net_req_i,
	input  logic                     net_req_v_i,
	output logic                     net_req_ready_o,
	input  logic [`MC_RSP_WIDTH-1:0] net_rsp_i,
	input  logic                     net_rsp_v_i,
	output logic                     net_rsp_ready_o,
	input  chan_e                    pop_chan_i,
	output logic                     pop_v_o,
	output mc_word_t                 pop_data_o,
	input  logic                     pop_yumi_i
);
	localparam int req_top_w_lp = `MC_REQ_WIDTH - (`MC_REQ_WORDS - 1) * `MC_WORD_WIDTH;
	localparam int rsp_top_w_lp = `MC_RSP_WIDTH - (`MC_RSP_WORDS - 1) * `MC_WORD_WIDTH;

	logic [`MC_NUM_CHAN-1:0] w_v;
	logic [`MC_NUM_CHAN-1:0] w_ready;
	logic [`MC_NUM_CHAN-1:0] r_v;
	logic [`MC_NUM_CHAN-1:0] yumi;
	mc_word_t wdata [`MC_NUM_CHAN];
	mc_word_t head [`MC_NUM_CHAN];
	logic chan_ok;

	// whole group must have room before a packet is taken
	assign net_req_ready_o = &w_ready[`MC_REQ_WORDS-1:0];
	assign net_rsp_ready_o = &w_ready[`MC_REQ_WORDS +: `MC_RSP_WORDS];
	assign w_v = {{`MC_RSP_WORDS{net_rsp_v_i && net_rsp_ready_o}},
		{`MC_REQ_WORDS{net_req_v_i && net_req_ready_o}}};

	assign wdata[CH_REQ0] = net_req_i[0*`MC_WORD_WIDTH +: `MC_WORD_WIDTH];
	assign wdata[CH_REQ1] = net_req_i[1*`MC_WORD_WIDTH +: `MC_WORD_WIDTH];
	assign wdata[CH_REQ2] = net_req_i[2*`MC_WORD_WIDTH +: `MC_WORD_WIDTH];
	// top words zero-extended
	assign wdata[CH_REQ3] = {{(`MC_WORD_WIDTH - req_top_w_lp){1'b0}},
		net_req_i[`MC_REQ_WIDTH-1 -: req_top_w_lp]};
	assign wdata[CH_RSP0] = net_rsp_i[`MC_WORD_WIDTH-1:0];
	assign wdata[CH_RSP1] = {{(`MC_WORD_WIDTH - rsp_top_w_lp){1'b0}},
		net_rsp_i[`MC_RSP_WIDTH-1 -: rsp_top_w_lp]};

	for (genvar i = 0; i < `MC_NUM_CHAN; i++)
	begin : g_chan
		assign yumi[i] = pop_yumi_i && (int'(pop_chan_i) == i);

		word_fifo #(.depth_p(`MC_FIFO_DEPTH)) fifo_inst
		(
			.clk_i     (clk_i),
			.rst_n_i   (rst_n_i),
			.w_v_i     (w_v[i]),
			.w_data_i  (wdata[i]),
			.w_ready_o (w_ready[i]),
			.r_v_o     (r_v[i]),
			.r_data_o  (head[i]),
			.r_yumi_i  (yumi[i])
		);
	end

	// host read selection
	assign chan_ok    = (pop_chan_i < `MC_NUM_CHAN);
	assign pop_v_o    = chan_ok && r_v[pop_chan_i];
	assign pop_data_o = chan_ok ? head[pop_chan_i] : '0;

endmodule

//--- source/csr_block.sv
//**************************************************************************
// host control and status registers, read mux and core reset
//**************************************************************************
`include "mc_bridge_cfg.svh"

module csr_block
	import mc_bridge_pkg::*;
(
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     csr_we_i,
	input  csr_addr_e                csr_addr_i,
	input  mc_word_t                 csr_wdata_i,
	output mc_word_t                 csr_rdata_o,
	input  logic                     range_err_i,
	input  logic [`MC_PROF_BITS-1:0] prof_i,
	output mc_word_t                 dram_base_o,
	output logic                     core_rst_o
);
	mc_word_t ctrl_r;
	mc_word_t base_r;

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			ctrl_r <= '0;
			base_r <= '0;
		end
		else if (csr_we_i)
		begin
			case (csr_addr_i)
				CSR_CTRL: ctrl_r <= csr_wdata_i;
				CSR_BASE: base_r <= csr_wdata_i;
				default:  ;
			endcase
		end
	end

	// core held in reset until the run bit is set
	assign core_rst_o  = ~ctrl_r[0];
	assign dram_base_o = base_r;

	always_comb
	begin
		csr_rdata_o = '0;
		case (csr_addr_i)
			CSR_CTRL:   csr_rdata_o = ctrl_r;
			CSR_BASE:   csr_rdata_o = base_r;
			CSR_STATUS: csr_rdata_o[1:0] = {ctrl_r[0], range_err_i};
			CSR_PROF0:  csr_rdata_o = prof_i[0*`MC_WORD_WIDTH +: `MC_WORD_WIDTH];
			CSR_PROF1:  csr_rdata_o = prof_i[1*`MC_WORD_WIDTH +: `MC_WORD_WIDTH];
			CSR_PROF2:  csr_rdata_o = prof_i[2*`MC_WORD_WIDTH +: `MC_WORD_WIDTH];
			CSR_PROF3:  csr_rdata_o = prof_i[3*`MC_WORD_WIDTH +: `MC_WORD_WIDTH];
			default:    csr_rdata_o = '0;
		endcase
	end

endmodule

//--- source/dram_remap.sv
//**************************************************************************
// maps core DRAM addresses into the host memory window and flags
// accesses past the memory limit
//**************************************************************************
`include "mc_bridge_cfg.svh"

module dram_remap
	import mc_bridge_pkg::*;
(
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      core_rst_i,
	input  logic [`MC_ADDR_WIDTH-1:0] core_awaddr_i,
	input  logic                      core_awvalid_i,
	input  logic [`MC_ADDR_WIDTH-1:0] core_araddr_i,
	input  logic                      core_arvalid_i,
	input  mc_word_t                  dram_base_i,
	output logic [`MC_ADDR_WIDTH-1:0] m_awaddr_o,
	output logic [`MC_ADDR_WIDTH-1:0] m_araddr_o,
	output logic                      range_err_o
);
	logic [`MC_ADDR_WIDTH-1:0] aw_flip;
	logic [`MC_ADDR_WIDTH-1:0] ar_flip;
	logic aw_bad;
	logic ar_bad;

	// top bit flip moves core DRAM space to offset zero
	assign aw_flip = core_awaddr_i ^ `MC_ADDR_FLIP;
	assign ar_flip = core_araddr_i ^ `MC_ADDR_FLIP;

	assign m_awaddr_o = aw_flip + dram_base_i;
	assign m_araddr_o = ar_flip + dram_base_i;

	assign aw_bad = core_awvalid_i && (aw_flip >= `MC_MEM_LIMIT);
	assign ar_bad = core_arvalid_i && (ar_flip >= `MC_MEM_LIMIT);

	// sticky until the core goes back into reset
	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i || core_rst_i)
			range_err_o <= 1'b0;
		else if (aw_bad || ar_bad)
			range_err_o <= 1'b1;
	end

endmodule

//--- source/access_profiler.sv
//**************************************************************************
// marks each 8 MiB DRAM region touched by a core write or read
//**************************************************************************
`include "mc_bridge_cfg.svh"

module access_profiler
(
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      core_rst_i,
	input  logic [`MC_ADDR_WIDTH-1:0] core_awaddr_i,
	input  logic                      core_awvalid_i,
	input  logic [`MC_ADDR_WIDTH-1:0] core_araddr_i,
	input  logic                      core_arvalid_i,
	output logic [`MC_PROF_BITS-1:0]  prof_o
);
	localparam int idx_w_lp = $clog2(`MC_PROF_BITS);

	logic [idx_w_lp-1:0] aw_idx;
	logic [idx_w_lp-1:0] ar_idx;
	logic [`MC_PROF_BITS-1:0] set_mask;

	// untranslated address bits 29 down to 23
	assign aw_idx = core_awaddr_i[`MC_PROF_LSB +: idx_w_lp];
	assign ar_idx = core_araddr_i[`MC_PROF_LSB +: idx_w_lp];

	// write and read may both mark in one cycle
	always_comb
	begin
		set_mask = '0;
		if (core_awvalid_i)
			set_mask[aw_idx] = 1'b1;
		if (core_arvalid_i)
			set_mask[ar_idx] = 1'b1;
	end

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i || core_rst_i)
			prof_o <= '0;
		else
			prof_o <= prof_o | set_mask;
	end

endmodule

//--- source/mc_host_bridge.sv
//**************************************************************************
// host bridge top: register port, word queues, packet ports, DRAM
// window remap and access profiler
//**************************************************************************
`include "mc_bridge_cfg.svh"

module mc_host_bridge
	import mc_bridge_pkg::*;
(
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      csr_we_i,
	input  csr_addr_e                 csr_addr_i,
	input  mc_word_t                  csr_wdata_i,
	output mc_word_t                  csr_rdata_o,
	input  logic                      push_v_i,
	input  chan_e                     push_chan_i,
	input  mc_word_t                  push_data_i,
	output logic                      push_ready_o,
	input  chan_e                     pop_chan_i,
	output logic                      pop_v_o,
	output mc_word_t                  pop_data_o,
	input  logic                      pop_yumi_i,
	output logic [`MC_REQ_WIDTH-1:0]  req_o,
	output logic                      req_v_o,
	input  logic                      req_ready_i,
	output logic [`MC_RSP_WIDTH-1:0]  rsp_o,
	output logic                      rsp_v_o,
	input  logic                      rsp_ready_i,
	input  logic [`MC_REQ_WIDTH-1:0]  net_req_i,
	input  logic                      net_req_v_i,
	output logic                      net_req_ready_o,
	input  logic [`MC_RSP_WIDTH-1:0]  net_rsp_i,
	input  logic                      net_rsp_v_i,
	output logic                      net_rsp_ready_o,
	input  logic [`MC_ADDR_WIDTH-1:0] core_awaddr_i,
	input  logic                      core_awvalid_i,
	input  logic [`MC_ADDR_WIDTH-1:0] core_araddr_i,
	input  logic                      core_arvalid_i,
	output logic [`MC_ADDR_WIDTH-1:0] m_awaddr_o,
	output logic [`MC_ADDR_WIDTH-1:0] m_araddr_o,
	output logic                      core_rst_o
);
	mc_word_t dram_base;
	logic range_err;
	logic [`MC_PROF_BITS-1:0] prof;

	csr_block csr_inst
	(
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.csr_we_i    (csr_we_i),
		.csr_addr_i  (csr_addr_i),
		.csr_wdata_i (csr_wdata_i),
		.csr_rdata_o (csr_rdata_o),
		.range_err_i (range_err),
		.prof_i      (prof),
		.dram_base_o (dram_base),
		.core_rst_o  (core_rst_o)
	);

	packet_gather gather_inst
	(
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.push_v_i     (push_v_i),
		.push_chan_i  (push_chan_i),
		.push_data_i  (push_data_i),
		.push_ready_o (push_ready_o),
		.req_o        (req_o),
		.req_v_o      (req_v_o),
		.req_ready_i  (req_ready_i),
		.rsp_o        (rsp_o),
		.rsp_v_o      (rsp_v_o),
		.rsp_ready_i  (rsp_ready_i)
	);

	packet_scatter scatter_inst
	(
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.net_req_i       (net_req_i),
		.net_req_v_i     (net_req_v_i),
		.net_req_ready_o (net_req_ready_o),
		.net_rsp_i       (net_rsp_i),
		.net_rsp_v_i     (net_rsp_v_i),
		.net_rsp_ready_o (net_rsp_ready_o),
		.pop_chan_i      (pop_chan_i),
		.pop_v_o         (pop_v_o),
		.pop_data_o      (pop_data_o),
		.pop_yumi_i      (pop_yumi_i)
	);

	dram_remap remap_inst
	(
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.core_rst_i     (core_rst_o),
		.core_awaddr_i  (core_awaddr_i),
		.core_awvalid_i (core_awvalid_i),
		.core_araddr_i  (core_araddr_i),
		.core_arvalid_i (core_arvalid_i),
		.dram_base_i    (dram_base),
		.m_awaddr_o     (m_awaddr_o),
		.m_araddr_o     (m_araddr_o),
		.range_err_o    (range_err)
	);

	access_profiler profiler_inst
	(
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.core_rst_i     (core_rst_o),
		.core_awaddr_i  (core_awaddr_i),
		.core_awvalid_i (core_awvalid_i),
		.core_araddr_i  (core_araddr_i),
		.core_arvalid_i (core_arvalid_i),
		.prof_o         (prof)
	);

endmodule

//--- bench/tb_mc_host_bridge.sv
//**************************************************************************
// testbench for the host bridge, replays bench/mc_bridge_cases.txt
// and compares each response with the value given on its line
//**************************************************************************
`include "mc_bridge_cfg.svh"

module tb_mc_host_bridge
	import mc_bridge_pkg::*;
();
	localparam int timeout_lp = 50;

	logic clk;
	logic rst_n;
	logic csr_we;
	csr_addr_e csr_addr;
	mc_word_t csr_wdata;
	mc_word_t csr_rdata;
	logic push_v;
	chan_e push_chan;
	mc_word_t push_data;
	logic push_ready;
	chan_e pop_chan;
	logic pop_v;
	mc_word_t pop_data;
	logic pop_yumi;
	logic [`MC_REQ_WIDTH-1:0] req;
	logic req_v;
	logic req_ready;
	logic [`MC_RSP_WIDTH-1:0] rsp;
	logic rsp_v;
	logic rsp_ready;
	logic [`MC_REQ_WIDTH-1:0] net_req;
	logic net_req_v;
	logic net_req_ready;
	logic [`MC_RSP_WIDTH-1:0] net_rsp;
	logic net_rsp_v;
	logic net_rsp_ready;
	logic [`MC_ADDR_WIDTH-1:0] core_awaddr;
	logic core_awvalid;
	logic [`MC_ADDR_WIDTH-1:0] core_araddr;
	logic core_arvalid;
	logic [`MC_ADDR_WIDTH-1:0] m_awaddr;
	logic [`MC_ADDR_WIDTH-1:0] m_araddr;
	logic core_rst;

	int checks;
	int errors;
	int timeouts;
	bit abort;

	mc_host_bridge mc_host_bridge_inst
	(
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.csr_we_i        (csr_we),
		.csr_addr_i      (csr_addr),
		.csr_wdata_i     (csr_wdata),
		.csr_rdata_o     (csr_rdata),
		.push_v_i        (push_v),
		.push_chan_i     (push_chan),
		.push_data_i     (push_data),
		.push_ready_o    (push_ready),
		.pop_chan_i      (pop_chan),
		.pop_v_o         (pop_v),
		.pop_data_o      (pop_data),
		.pop_yumi_i      (pop_yumi),
		.req_o           (req),
		.req_v_o         (req_v),
		.req_ready_i     (req_ready),
		.rsp_o           (rsp),
		.rsp_v_o         (rsp_v),
		.rsp_ready_i     (rsp_ready),
		.net_req_i       (net_req),
		.net_req_v_i     (net_req_v),
		.net_req_ready_o (net_req_ready),
		.net_rsp_i       (net_rsp),
		.net_rsp_v_i     (net_rsp_v),
		.net_rsp_ready_o (net_rsp_ready),
		.core_awaddr_i   (core_awaddr),
		.core_awvalid_i  (core_awvalid),
		.core_araddr_i   (core_araddr),
		.core_arvalid_i  (core_arvalid),
		.m_awaddr_o      (m_awaddr),
		.m_araddr_o      (m_araddr),
		.core_rst_o      (core_rst)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// inputs change 2 units after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// single-bit outputs picked by the select column of the case file
	function automatic logic flag_value(input int sel);
		case (sel)
			0: return req_v;
			1: return rsp_v;
			2: return core_rst;
			3: return net_req_ready;
			4: return net_rsp_ready;
			5: return pop_v;
			default: return push_ready;
		endcase
	endfunction

	// sampled mid-cycle, returns at the falling edge once seen
	task automatic wait_high(input int sel, input string name, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < timeout_lp)
		begin
			@(negedge clk);
			if (flag_value(sel))
				seen = 1'b1;
			else
			begin
				n++;
				next_cycle();
			end
		end
		if (!seen)
		begin
			timeouts++;
			abort = 1'b1;
			$display("timeout in %s: signal %0d stayed low for %0d cycles", name, sel,
				timeout_lp);
		end
	endtask

	// waits for an outbound packet, holds ready low for stall cycles, then takes it
	task automatic take_packet(input bit is_rsp, input string name, input int stall,
		input logic [127:0] exp);
		bit seen;
		wait_high(is_rsp ? 1 : 0, name, seen);
		if (seen)
		begin
			check_value(name, exp, is_rsp ? 128'(rsp) : 128'(req));
			repeat (stall)
			begin
				next_cycle();
				@(negedge clk);
				check_value(name, 128'd1, 128'(flag_value(is_rsp ? 1 : 0)));
				check_value(name, exp, is_rsp ? 128'(rsp) : 128'(req));
			end
			next_cycle();
			req_ready = !is_rsp;
			rsp_ready = is_rsp;
			next_cycle();
			req_ready = 1'b0;
			rsp_ready = 1'b0;
		end
	endtask

	task automatic inject_packet(input bit is_rsp, input string name,
		input logic [127:0] pkt);
		bit seen;
		net_req = pkt[`MC_REQ_WIDTH-1:0];
		net_rsp = pkt[`MC_RSP_WIDTH-1:0];
		net_req_v = !is_rsp;
		net_rsp_v = is_rsp;
		wait_high(is_rsp ? 4 : 3, name, seen);
		if (seen)
			next_cycle();
		net_req_v = 1'b0;
		net_rsp_v = 1'b0;
	endtask

	// one-cycle valid address, remapped output checked mid-cycle
	task automatic drive_address(input bit is_read, input string name,
		input logic [127:0] addr, input logic [127:0] exp);
		core_awaddr = addr[31:0];
		core_araddr = addr[31:0];
		core_awvalid = !is_read;
		core_arvalid = is_read;
		@(negedge clk);
		check_value(name, exp, is_read ? 128'(m_araddr) : 128'(m_awaddr));
		next_cycle();
		core_awvalid = 1'b0;
		core_arvalid = 1'b0;
	endtask

	// an empty response queue takes depth words, then push ready must drop
	task automatic fill_until_full(input string name);
		bit seen;
		push_chan = CH_RSP0;
		push_v = 1'b1;
		for (int i = 0; i < `MC_FIFO_DEPTH; i++)
		begin
			push_data = 32'(i);
			wait_high(6, name, seen);
			if (seen)
				next_cycle();
		end
		push_v = 1'b0;
		@(negedge clk);
		check_value(name, 128'd0, 128'(push_ready));
		next_cycle();
	endtask

	task automatic run_case(input string op, input string name, input logic [127:0] arg,
		input logic [127:0] val);
		bit seen;
		case (op)
			"wr":
			begin
				csr_addr = csr_addr_e'(arg[3:0]);
				csr_wdata = val[31:0];
				csr_we = 1'b1;
				next_cycle();
				csr_we = 1'b0;
			end
			"rd":
			begin
				csr_addr = csr_addr_e'(arg[3:0]);
				@(negedge clk);
				check_value(name, val, 128'(csr_rdata));
				next_cycle();
			end
			"flag":
			begin
				@(negedge clk);
				check_value(name, val, 128'(flag_value(int'(arg[31:0]))));
				next_cycle();
			end
			"push":
			begin
				push_chan = chan_e'(arg[2:0]);
				push_data = val[31:0];
				push_v = 1'b1;
				wait_high(6, name, seen);
				if (seen)
					next_cycle();
				push_v = 1'b0;
			end
			"pop":
			begin
				pop_chan = chan_e'(arg[2:0]);
				wait_high(5, name, seen);
				if (seen)
				begin
					check_value(name, val, 128'(pop_data));
					next_cycle();
					pop_yumi = 1'b1;
					next_cycle();
					pop_yumi = 1'b0;
				end
			end
			"req": take_packet(1'b0, name, int'(arg[31:0]), val);
			"rsp": take_packet(1'b1, name, int'(arg[31:0]), val);
			"ireq": inject_packet(1'b0, name, val);
			"irsp": inject_packet(1'b1, name, val);
			"aw": drive_address(1'b0, name, arg, val);
			"ar": drive_address(1'b1, name, arg, val);
			default:
			begin
				errors++;
				$display("unknown operation %s in case %s", op, name);
			end
		endcase
	endtask

	initial
	begin
		int fd;
		int n;
		string line;
		string op;
		string name;
		logic [127:0] arg;
		logic [127:0] val;

		checks = 0;
		errors = 0;
		timeouts = 0;
		abort = 1'b0;
		rst_n = 1'b0;
		csr_we = 1'b0;
		csr_addr = CSR_CTRL;
		csr_wdata = '0;
		push_v = 1'b0;
		push_chan = CH_REQ0;
		push_data = '0;
		pop_chan = CH_REQ0;
		pop_yumi = 1'b0;
		req_ready = 1'b0;
		rsp_ready = 1'b0;
		net_req = '0;
		net_req_v = 1'b0;
		net_rsp = '0;
		net_rsp_v = 1'b0;
		core_awaddr = '0;
		core_awvalid = 1'b0;
		core_araddr = '0;
		core_arvalid = 1'b0;

		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;

		fd = $fopen("bench/mc_bridge_cases.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the case file bench/mc_bridge_cases.txt");
		end
		else
		begin
			while (!abort && !$feof(fd))
			begin
				line = "";
				if ($fgets(line, fd) != 0)
				begin
					n = $sscanf(line, "%s %s %h %h", op, name, arg, val);
					// comment and blank lines skipped
					if (n == 4 && op.getc(0) != "#")
						run_case(op, name, arg, val);
				end
			end
			$fclose(fd);
			// queues are drained at the end of the case file
			if (!abort)
				fill_until_full("push_full");
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
source/mc_bridge_pkg.sv
source/word_fifo.sv
source/packet_gather.sv
source/packet_scatter.sv
source/csr_block.sv
source/dram_remap.sv
source/access_profiler.sv
source/mc_host_bridge.sv
bench/tb_mc_host_bridge.sv

//--- bench/mc_bridge_cases.txt
# op test arg value, arg and value in hex, lines starting with # are skipped
# arg is a register, channel, address, flag select or stall count, as the op needs
flag reset_req_v 0 0
flag reset_rsp_v 1 0
flag reset_core_rst 2 1
flag reset_net_req_ready 3 1
flag reset_net_rsp_ready 4 1
flag reset_pop_v 5 0
rd reset_status 3 0
wr run_on 0 1
rd run_status 3 2
flag run_core_rst 2 0
push req_a0 0 11110000
push req_a1 1 22221111
push req_a2 2 33332222
flag req_partial 0 0
push req_a3 3 ffff4444
push req_b0 0 aaaa0001
push req_b1 1 bbbb0002
push req_b2 2 cccc0003
push req_b3 3 00005555
req req_a_stalled 3 4444333322222222111111110000
req req_b 0 5555cccc0003bbbb0002aaaa0001
flag req_drained 0 0
push rsp_w0 4 12345678
flag rsp_partial 1 0
push rsp_w1 5 dead9abc
rsp rsp_stalled 2 9abc12345678
flag rsp_drained 1 0
ireq in_req_a 0 beef090a0b0c0506070801020304
ireq in_req_b 0 d3d3c2c2c2c2b1b1b1b1a0a0a0a0
pop in_req_a0 0 01020304
pop in_req_a1 1 05060708
pop in_req_a2 2 090a0b0c
pop in_req_a3 3 0000beef
pop in_req_b0 0 a0a0a0a0
pop in_req_b1 1 b1b1b1b1
pop in_req_b2 2 c2c2c2c2
pop in_req_b3 3 0000d3d3
irsp in_rsp 0 777789abcdef
pop in_rsp0 4 89abcdef
pop in_rsp1 5 00007777
flag pop_empty 5 0
wr base_set 2 10000000
rd base_read 2 10000000
rd hole_reg 1 0
rd hole_reg_high 8 0
aw remap_aw0 80001000 10001000
ar remap_ar0 81000040 11000040
aw remap_aw1 86000000 16000000
rd in_range_status 3 2
rd prof0_in_range 4 1005
ar range_ar 90000000 20000000
rd range_status 3 3
aw later_ok 80000000 10000000
rd range_sticky 3 3
aw prof_top 3f800000 cf800000
ar prof_mid 20000000 b0000000
rd prof0 4 1005
rd prof1 5 1
rd prof2 6 1
rd prof3 7 80000000
wr run_off 0 0
rd off_ctrl 0 0
rd off_status 3 0
rd off_prof0 4 0
rd off_prof1 5 0
rd off_prof2 6 0
rd off_prof3 7 0
flag off_core_rst 2 1
